/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // line geometry
  localparam int WORDS = 4;
  localparam int WORD_BITS = 32;

  // the low IDX_BITS of a line address pick the set and the rest is the tag
  localparam int LINE_ADDR_BITS = 16;

  // one cache line with word 0 in the low bits
  typedef struct packed {
    logic [WORDS-1:0][WORD_BITS-1:0] word;
  } line_t;

  // one fetched flag per word of a line
  typedef logic [WORDS-1:0] flags_t;

  typedef struct packed {
    logic en;
    // marks the selected word as fetched on a hit
    logic set_flag;
    logic [1:0] word;
    logic [LINE_ADDR_BITS-1:0] line_addr;
  } read_req_t;

  typedef struct packed {
    logic en;
    logic [LINE_ADDR_BITS-1:0] line_addr;
    line_t data;
  } write_req_t;

  typedef struct packed {
    logic hit;
    flags_t flags;
    line_t data;
  } read_rsp_t;

  // the array clears itself one set per cycle in st_sweep
  typedef enum logic {
    st_sweep,
    st_run
  } init_state_t;

endpackage

`default_nettype wire

/* icache_line_ram.sv */
`default_nettype none

module icache_line_ram #(
  parameter int IDX_BITS = 5,
  parameter int DATA_BITS = 128
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 read_en,
  input  logic [IDX_BITS-1:0]  read_addr,
  output logic [DATA_BITS-1:0] read_data,
  input  logic                 write_en,
  input  logic [IDX_BITS-1:0]  write_addr,
  input  logic [DATA_BITS-1:0] write_data
);

  localparam int DEPTH = 2 ** IDX_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];
  logic [IDX_BITS-1:0] read_addr_q;

  // the address is held between reads so the output keeps showing the last line
  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_q <= '0;
    end else if (read_en) begin
      read_addr_q <= read_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  // a write at the same edge as the address load is visible at once
  assign read_data = mem[read_addr_q];

endmodule

`default_nettype wire

/* icache_tag_array.sv */
`default_nettype none

module icache_tag_array #(
  parameter int IDX_BITS = 5
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  init,
  input  logic [IDX_BITS-1:0]                   init_index,
  input  logic                                  rd_en,
  input  logic [icache_pkg::LINE_ADDR_BITS-1:0] rd_addr,
  output logic                                  rd_hit,
  input  logic [icache_pkg::LINE_ADDR_BITS-1:0] wr_addr,
  output logic                                  wr_match,
  input  logic                                  fill_en
);

  import icache_pkg::*;

  localparam int DEPTH = 2 ** IDX_BITS;
  localparam int TAG_BITS = LINE_ADDR_BITS - IDX_BITS;

  logic [DEPTH-1:0] valid;
  logic [TAG_BITS-1:0] tag_mem [DEPTH];

  logic [IDX_BITS-1:0] rd_index;
  logic [TAG_BITS-1:0] rd_tag;
  logic [IDX_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0] wr_tag;

  logic rd_en_q;
  logic [IDX_BITS-1:0] rd_index_q;
  logic [TAG_BITS-1:0] rd_tag_q;

  assign rd_index = rd_addr[IDX_BITS-1:0];
  assign rd_tag = rd_addr[LINE_ADDR_BITS-1:IDX_BITS];
  assign wr_index = wr_addr[IDX_BITS-1:0];
  assign wr_tag = wr_addr[LINE_ADDR_BITS-1:IDX_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_index_q <= rd_index;
      rd_tag_q <= rd_tag;
    end
  end

  // the sweep and a fill never overlap because requests are held off during init
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (init) begin
      valid[init_index] <= 1'b0;
    end else if (fill_en) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_mem[wr_index] <= wr_tag;
    end
  end

  // compares against the array contents after the edge that sampled the read
  assign rd_hit = rd_en_q && valid[rd_index_q] && (tag_mem[rd_index_q] == rd_tag_q);

  assign wr_match = valid[wr_index] && (tag_mem[wr_index] == wr_tag);

endmodule

`default_nettype wire

/* icache_way.sv */
`default_nettype none

module icache_way #(
  parameter int IDX_BITS = 5
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   init,
  input  logic [IDX_BITS-1:0]    init_index,
  input  icache_pkg::read_req_t  rd,
  input  icache_pkg::write_req_t wr,
  input  logic                   fill_en,
  output logic                   wr_match,
  output logic                   hit,
  input  icache_pkg::read_rsp_t  rsp_in,
  output icache_pkg::read_rsp_t  rsp_out
);

  import icache_pkg::*;

  logic [IDX_BITS-1:0] rd_index;
  logic [IDX_BITS-1:0] wr_index;

  logic rd_set_flag_q;
  logic [1:0] rd_word_q;
  logic [IDX_BITS-1:0] rd_index_q;

  line_t data_ram;
  flags_t flags_ram;
  flags_t flags_new;

  logic flag_we;
  logic [IDX_BITS-1:0] flag_waddr;
  flags_t flag_wdata;

  read_rsp_t rsp_own;

  assign rd_index = rd.line_addr[IDX_BITS-1:0];
  assign wr_index = wr.line_addr[IDX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_set_flag_q <= 1'b0;
    end else begin
      rd_set_flag_q <= rd.en & rd.set_flag;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_word_q <= rd.word;
      rd_index_q <= rd_index;
    end
  end

  icache_tag_array #(
    .IDX_BITS(IDX_BITS)
  ) u_tags (
    .clk       (clk),
    .rst       (rst),
    .init      (init),
    .init_index(init_index),
    .rd_en     (rd.en),
    .rd_addr   (rd.line_addr),
    .rd_hit    (hit),
    .wr_addr   (wr.line_addr),
    .wr_match  (wr_match),
    .fill_en   (fill_en)
  );

  icache_line_ram #(
    .IDX_BITS (IDX_BITS),
    .DATA_BITS($bits(line_t))
  ) u_data (
    .clk       (clk),
    .rst       (rst),
    .read_en   (rd.en),
    .read_addr (rd_index),
    .read_data (data_ram),
    .write_en  (fill_en),
    .write_addr(wr_index),
    .write_data(wr.data)
  );

  icache_line_ram #(
    .IDX_BITS (IDX_BITS),
    .DATA_BITS(WORDS)
  ) u_flags (
    .clk       (clk),
    .rst       (rst),
    .read_en   (rd.en),
    .read_addr (rd_index),
    .read_data (flags_ram),
    .write_en  (flag_we),
    .write_addr(flag_waddr),
    .write_data(flag_wdata)
  );

  // the response already carries the bit that is being written back
  assign flags_new = flags_ram | (flags_t'(rd_set_flag_q) << rd_word_q);

  // one write port for the flags
  // a fill in the same cycle as a flag write-back drops the write-back
  always_comb begin
    flag_we = 1'b0;
    flag_waddr = rd_index_q;
    flag_wdata = flags_new;
    if (init) begin
      flag_we = 1'b1;
      flag_waddr = init_index;
      flag_wdata = '0;
    end else if (fill_en) begin
      flag_we = 1'b1;
      flag_waddr = wr_index;
      flag_wdata = '0;
    end else if (hit && rd_set_flag_q) begin
      flag_we = 1'b1;
    end
  end

  // only the hitting way puts anything on the chain
  always_comb begin
    rsp_own.hit = hit;
    rsp_own.flags = hit ? flags_new : '0;
    rsp_own.data = hit ? data_ram : '0;
  end

  assign rsp_out = read_rsp_t'(rsp_own | rsp_in);

endmodule

`default_nettype wire

/* icache_nru.sv */
`default_nettype none

module icache_nru #(
  parameter int IDX_BITS = 5,
  parameter int WAYS = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                init,
  input  logic [IDX_BITS-1:0] init_index,
  input  logic [IDX_BITS-1:0] wr_index,
  input  logic [WAYS-1:0]     fill,
  input  logic [IDX_BITS-1:0] hit_index,
  input  logic [WAYS-1:0]     hit_way,
  output logic [WAYS-1:0]     victim
);

  localparam int DEPTH = 2 ** IDX_BITS;

  logic [WAYS-1:0] nru [DEPTH];
  logic [WAYS-1:0] wr_bits;
  logic found;
  logic hit_upd;

  // mark a way as used and start a new round when every way would be marked
  function automatic logic [WAYS-1:0] touch(input logic [WAYS-1:0] bits,
                                            input logic [WAYS-1:0] way);
    logic [WAYS-1:0] next;
    next = bits | way;
    if (&next) begin
      next = way;
    end
    return next;
  endfunction

  assign wr_bits = nru[wr_index];

  always_comb begin
    victim = '0;
    found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (!found && !wr_bits[w]) begin
        victim[w] = 1'b1;
        found = 1'b1;
      end
    end
    // touch() leaves a set full only when there is a single way
    if (!found) begin
      victim[0] = 1'b1;
    end
  end

  // a fill to the same set overrides the hit update
  assign hit_upd = (|hit_way) && !((|fill) && (hit_index == wr_index));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < DEPTH; s++) begin
        nru[s] <= '0;
      end
    end else if (init) begin
      nru[init_index] <= '0;
    end else begin
      if (hit_upd) begin
        nru[hit_index] <= touch(nru[hit_index], hit_way);
      end
      if (|fill) begin
        nru[wr_index] <= touch(wr_bits, fill);
      end
    end
  end

endmodule

`default_nettype wire

/* icache_array.sv */
`default_nettype none

module icache_array #(
  parameter int IDX_BITS = 5,
  parameter int WAYS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   invalidate,
  input  icache_pkg::read_req_t  rd,
  input  icache_pkg::write_req_t wr,
  output icache_pkg::read_rsp_t  rsp,
  output logic [WAYS-1:0]        rsp_way,
  output logic                   ready
);

  import icache_pkg::*;

  init_state_t state;
  logic [IDX_BITS-1:0] sweep_cnt;
  logic init;

  read_req_t rd_g;
  write_req_t wr_g;

  logic [IDX_BITS-1:0] wr_index;
  logic [IDX_BITS-1:0] rd_index_q;

  logic [WAYS-1:0] wr_match;
  logic [WAYS-1:0] hit_way;
  logic [WAYS-1:0] victim;
  logic [WAYS-1:0] fill;

  // chain[k] feeds way k and chain[WAYS] is the merged response
  read_rsp_t chain [WAYS+1];

  // invalidate restarts the sweep from set 0 even in the middle of one
  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      state <= st_sweep;
      sweep_cnt <= '0;
    end else if (state == st_sweep) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (&sweep_cnt) begin
        state <= st_run;
      end
    end
  end

  assign init = (state == st_sweep);
  assign ready = (state == st_run);

  always_comb begin
    rd_g = rd;
    rd_g.en = rd.en & ready;
    wr_g = wr;
    wr_g.en = wr.en & ready;
  end

  assign wr_index = wr.line_addr[IDX_BITS-1:0];

  // a line already present is refilled in place, otherwise the NRU victim is used
  always_comb begin
    fill = '0;
    if (wr_g.en) begin
      fill = (|wr_match) ? wr_match : victim;
    end
  end

  // set of the read whose hit comes back in the next cycle
  always_ff @(posedge clk) begin
    if (rd_g.en) begin
      rd_index_q <= rd.line_addr[IDX_BITS-1:0];
    end
  end

  assign chain[0] = '0;

  for (genvar k = 0; k < WAYS; k++) begin : g_way
    icache_way #(
      .IDX_BITS(IDX_BITS)
    ) u_way (
      .clk       (clk),
      .rst       (rst),
      .init      (init),
      .init_index(sweep_cnt),
      .rd        (rd_g),
      .wr        (wr_g),
      .fill_en   (fill[k]),
      .wr_match  (wr_match[k]),
      .hit       (hit_way[k]),
      .rsp_in    (chain[k]),
      .rsp_out   (chain[k+1])
    );
  end

  icache_nru #(
    .IDX_BITS(IDX_BITS),
    .WAYS    (WAYS)
  ) u_nru (
    .clk       (clk),
    .rst       (rst),
    .init      (init),
    .init_index(sweep_cnt),
    .wr_index  (wr_index),
    .fill      (fill),
    .hit_index (rd_index_q),
    .hit_way   (hit_way),
    .victim    (victim)
  );

  assign rsp = chain[WAYS];
  assign rsp_way = hit_way;

endmodule

`default_nettype wire

/* tb_icache.sv */
`default_nettype none

module tb_icache;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  localparam int IDX_BITS = 5;
  localparam int WAYS = 4;
  localparam int SETS = 2 ** IDX_BITS;
  localparam int SWEEP_LIMIT = 4 * SETS;
  localparam logic [31:0] RNG_SEED = 32'haef7fb8f;

  typedef enum logic [2:0] {
    op_idle,
    op_read,
    op_write,
    op_rw,
    op_inv
  } op_t;

  typedef struct packed {
    op_t op;
    logic [LINE_ADDR_BITS-1:0] rd_addr;
    logic [LINE_ADDR_BITS-1:0] wr_addr;
    logic [1:0] word;
    logic set_flag;
    logic [15:0] seed;
  } step_t;

  localparam step_t IDLE_STEP = '0;

  logic clk = 1'b0;
  logic rst;
  logic invalidate;
  read_req_t rd;
  write_req_t wr;
  read_rsp_t rsp;
  logic [WAYS-1:0] rsp_way;
  logic ready;

  step_t steps[$];
  step_t last;
  int errors;
  int checks;
  bit timed_out;
  bit sweeping;
  bit expect_low;

  // reference copy of the array contents
  bit m_valid [WAYS][SETS];
  logic [LINE_ADDR_BITS-1:0] m_addr [WAYS][SETS];
  line_t m_data [WAYS][SETS];
  flags_t m_flags [WAYS][SETS];
  logic [WAYS-1:0] m_nru [SETS];

  // a read hit whose NRU and flag update land on the next edge
  bit p_hit;
  int p_way;
  int p_set;
  bit p_set_flag;
  flags_t p_flags;

  read_rsp_t exp_rsp;
  logic [WAYS-1:0] exp_way;

  always #50 clk = ~clk;

  icache_array #(
    .IDX_BITS(IDX_BITS),
    .WAYS    (WAYS)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .invalidate(invalidate),
    .rd        (rd),
    .wr        (wr),
    .rsp       (rsp),
    .rsp_way   (rsp_way),
    .ready     (ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic line_t make_line(input logic [15:0] seed);
    line_t l;
    logic [31:0] s;
    s = xorshift32(RNG_SEED ^ {16'h0, seed});
    for (int w = 0; w < WORDS; w++) begin
      s = xorshift32(s);
      l.word[w] = s;
    end
    return l;
  endfunction

  function automatic logic [LINE_ADDR_BITS-1:0] line_of(input int tag, input int idx);
    return LINE_ADDR_BITS'((tag << IDX_BITS) | idx);
  endfunction

  // a used way gets its bit set, and a full set starts over with only that way
  function automatic logic [WAYS-1:0] mark_used(input logic [WAYS-1:0] bits, input int way);
    logic [WAYS-1:0] bits_n;
    bits_n = bits;
    bits_n[way] = 1'b1;
    if (&bits_n) begin
      bits_n = '0;
      bits_n[way] = 1'b1;
    end
    return bits_n;
  endfunction

  function automatic int find_way(input logic [LINE_ADDR_BITS-1:0] addr);
    int idx;
    int found;
    idx = addr[IDX_BITS-1:0];
    found = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][idx] && m_addr[w][idx] == addr) begin
        found = w;
      end
    end
    return found;
  endfunction

  task automatic clear_model();
    for (int w = 0; w < WAYS; w++) begin
      for (int s = 0; s < SETS; s++) begin
        m_valid[w][s] = 1'b0;
        m_flags[w][s] = '0;
      end
    end
    for (int s = 0; s < SETS; s++) begin
      m_nru[s] = '0;
    end
  endtask

  // mirrors what the array does at the edge that samples step s
  task automatic model_edge(input step_t s);
    int fw;
    int hw;
    int ws;
    int rs;
    fw = -1;
    ws = s.wr_addr[IDX_BITS-1:0];
    rs = s.rd_addr[IDX_BITS-1:0];
    if (s.op == op_inv) begin
      clear_model();
      sweeping = 1'b1;
      expect_low = 1'b1;
    end
    if (sweeping) begin
      p_hit = 1'b0;
      exp_rsp = '0;
      exp_way = '0;
      return;
    end
    if (s.op == op_write || s.op == op_rw) begin
      fw = find_way(s.wr_addr);
      if (fw < 0) begin
        fw = 0;
        for (int w = WAYS - 1; w >= 0; w--) begin
          if (!m_nru[ws][w]) begin
            fw = w;
          end
        end
      end
    end
    // the flag RAM has one write port, so a fill in the hit way drops the write-back
    if (p_hit) begin
      if (!(fw >= 0 && p_set == ws)) begin
        m_nru[p_set] = mark_used(m_nru[p_set], p_way);
      end
      if (p_set_flag && fw != p_way) begin
        m_flags[p_way][p_set] = p_flags;
      end
    end
    if (fw >= 0) begin
      m_valid[fw][ws] = 1'b1;
      m_addr[fw][ws] = s.wr_addr;
      m_data[fw][ws] = make_line(s.seed);
      m_flags[fw][ws] = '0;
      m_nru[ws] = mark_used(m_nru[ws], fw);
    end
    p_hit = 1'b0;
    exp_rsp = '0;
    exp_way = '0;
    if (s.op == op_read || s.op == op_rw) begin
      hw = find_way(s.rd_addr);
      if (hw >= 0) begin
        p_hit = 1'b1;
        p_way = hw;
        p_set = rs;
        p_set_flag = s.set_flag;
        p_flags = m_flags[hw][rs];
        if (s.set_flag) begin
          p_flags[s.word] = 1'b1;
        end
        exp_rsp.hit = 1'b1;
        exp_rsp.flags = p_flags;
        exp_rsp.data = m_data[hw][rs];
        exp_way[hw] = 1'b1;
      end
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_outputs();
    checks++;
    if (rsp !== exp_rsp) begin
      report_error($sformatf("rsp hit=%b flags=%b data=%h, expected hit=%b flags=%b data=%h",
                             rsp.hit, rsp.flags, rsp.data,
                             exp_rsp.hit, exp_rsp.flags, exp_rsp.data));
    end
    if (rsp_way !== exp_way) begin
      report_error($sformatf("rsp_way %b, expected %b", rsp_way, exp_way));
    end
    if (expect_low) begin
      if (ready !== 1'b0) begin
        report_error($sformatf("ready %b during the sweep, expected 0", ready));
      end
      expect_low = 1'b0;
    end else if (!sweeping && ready !== 1'b1) begin
      report_error($sformatf("ready %b after the sweep, expected 1", ready));
    end
  endtask

  // each call models the sampled step, drives the next one and checks at the falling edge
  task automatic run_cycle(input step_t s);
    read_req_t r;
    write_req_t w;
    @(posedge clk);
    model_edge(last);
    r = '0;
    w = '0;
    r.en = (s.op == op_read || s.op == op_rw);
    r.set_flag = s.set_flag;
    r.word = s.word;
    r.line_addr = s.rd_addr;
    w.en = (s.op == op_write || s.op == op_rw);
    w.line_addr = s.wr_addr;
    w.data = w.en ? make_line(s.seed) : '0;
    rd <= r;
    wr <= w;
    invalidate <= (s.op == op_inv);
    last = s;
    @(negedge clk);
    check_outputs();
  endtask

  // the sweep takes one cycle per set, so ready must first be seen on cycle rise_at
  task automatic wait_ready(input int rise_at);
    int n;
    n = 0;
    while (sweeping && !timed_out) begin
      run_cycle(IDLE_STEP);
      n++;
      if (ready === 1'b1) begin
        if (n != rise_at) begin
          report_error($sformatf("ready rose after %0d cycles, expected %0d", n, rise_at));
        end
        sweeping = 1'b0;
      end else if (n >= SWEEP_LIMIT) begin
        $display("timeout: ready did not rise within %0d cycles", n);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic add_step(input op_t op, input int rtag, input int ridx, input int wtag,
                          input int widx, input int word, input bit set_flag, input int seed);
    step_t s;
    s.op = op;
    s.rd_addr = line_of(rtag, ridx);
    s.wr_addr = line_of(wtag, widx);
    s.word = word[1:0];
    s.set_flag = set_flag;
    s.seed = seed[15:0];
    steps.push_back(s);
  endtask

  task automatic build_table();
    // the empty cache misses, also on the line offered during the sweep
    add_step(op_read, 1, 0, 0, 0, 0, 0, 0);
    add_step(op_read, 9, 9, 0, 0, 0, 0, 0);
    // one line in each of three sets
    add_step(op_write, 0, 0, 1, 1, 0, 0, 'h11);
    add_step(op_write, 0, 0, 2, 2, 0, 0, 'h22);
    add_step(op_write, 0, 0, 3, 3, 0, 0, 'h33);
    add_step(op_read, 1, 1, 0, 0, 0, 0, 0);
    add_step(op_read, 2, 2, 0, 0, 1, 0, 0);
    add_step(op_read, 3, 3, 0, 0, 3, 0, 0);
    add_step(op_read, 2, 3, 0, 0, 0, 0, 0);
    // more lines than ways in set 4
    add_step(op_write, 0, 0, 10, 4, 0, 0, 'h41);
    add_step(op_write, 0, 0, 11, 4, 0, 0, 'h42);
    add_step(op_write, 0, 0, 12, 4, 0, 0, 'h43);
    add_step(op_write, 0, 0, 13, 4, 0, 0, 'h44);
    add_step(op_write, 0, 0, 14, 4, 0, 0, 'h45);
    add_step(op_read, 10, 4, 0, 0, 0, 0, 0);
    add_step(op_read, 11, 4, 0, 0, 0, 0, 0);
    add_step(op_write, 0, 0, 15, 4, 0, 0, 'h46);
    add_step(op_read, 12, 4, 0, 0, 0, 0, 0);
    add_step(op_write, 0, 0, 13, 4, 0, 0, 'h47);
    add_step(op_read, 13, 4, 0, 0, 2, 0, 0);
    // fetched flags accumulate until the line is refilled
    add_step(op_read, 1, 1, 0, 0, 2, 1, 0);
    add_step(op_read, 1, 1, 0, 0, 0, 1, 0);
    add_step(op_idle, 0, 0, 0, 0, 0, 0, 0);
    add_step(op_read, 1, 1, 0, 0, 2, 1, 0);
    add_step(op_read, 1, 1, 0, 0, 3, 0, 0);
    add_step(op_write, 0, 0, 1, 1, 0, 0, 'h12);
    add_step(op_read, 1, 1, 0, 0, 1, 1, 0);
    add_step(op_read, 1, 1, 0, 0, 1, 0, 0);
    // hit updates that collide with fills in set 6
    add_step(op_write, 0, 0, 20, 6, 0, 0, 'h61);
    add_step(op_write, 0, 0, 21, 6, 0, 0, 'h62);
    add_step(op_read, 21, 6, 0, 0, 0, 0, 0);
    add_step(op_write, 0, 0, 22, 6, 0, 0, 'h63);
    add_step(op_rw, 20, 6, 23, 6, 0, 0, 'h64);
    add_step(op_write, 0, 0, 24, 6, 0, 0, 'h65);
    add_step(op_read, 20, 6, 0, 0, 0, 0, 0);
    add_step(op_read, 21, 6, 0, 0, 0, 0, 0);
    add_step(op_read, 22, 6, 0, 0, 0, 0, 0);
    // everything misses after an invalidate
    add_step(op_inv, 0, 0, 0, 0, 0, 0, 0);
    add_step(op_read, 1, 1, 0, 0, 0, 0, 0);
    add_step(op_read, 13, 4, 0, 0, 0, 0, 0);
    add_step(op_read, 24, 6, 0, 0, 0, 0, 0);
    add_step(op_write, 0, 0, 1, 1, 0, 0, 'h13);
    add_step(op_read, 1, 1, 0, 0, 0, 0, 0);
    add_step(op_idle, 0, 0, 0, 0, 0, 0, 0);
    add_step(op_idle, 0, 0, 0, 0, 0, 0, 0);
  endtask

  initial begin
    step_t early;
    rst = 1'b1;
    invalidate = 1'b0;
    rd = '0;
    wr = '0;
    errors = 0;
    checks = 0;
    timed_out = 1'b0;
    sweeping = 1'b1;
    expect_low = 1'b0;
    p_hit = 1'b0;
    exp_rsp = '0;
    exp_way = '0;
    last = IDLE_STEP;
    clear_model();
    build_table();

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_low = 1'b1;
    check_outputs();

    // offered while ready is low, so it must leave no trace
    early = IDLE_STEP;
    early.op = op_rw;
    early.rd_addr = line_of(9, 9);
    early.wr_addr = line_of(9, 9);
    early.seed = 16'h99;
    run_cycle(early);
    // the first sweep cycle has already passed with the early step
    wait_ready(SETS - 1);

    for (int i = 0; i < steps.size(); i++) begin
      if (timed_out) begin
        break;
      end
      run_cycle(steps[i]);
      if (steps[i].op == op_inv) begin
        run_cycle(IDLE_STEP);
        wait_ready(SETS);
      end
    end

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* icache.f */
icache_pkg.sv
icache_line_ram.sv
icache_tag_array.sv
icache_way.sv
icache_nru.sv
icache_array.sv
tb_icache.sv
